// ==== build.f ====
+incdir+.
framerPkg.sv
framerRegs.sv
syncCorrelator.sv
frameSync.sv
frameBuffer.sv
framerTop.sv
framerTb_asserts.sv
framerTb.sv

// ==== framerTb.sv ====
`timescale 1ns/1ns
`include "addressMap_defs.svh"

module framerTb
    import framerPkg::*;
();

    localparam int      CLK_HALF     = 4;
    localparam int      RESET_CYCLES = 5;
    localparam busData  SYNC_WORD    = 32'h1ACF_FC1D;
    localparam busData  CTRL_USED    = 32'hFFFF_7F1F;
    localparam busData  THRESH_MASK  = 32'hFFFF_0FFF;

    // A word is written two and a half cycles after the strobe of its last bit,
    // and a read sampled at a falling edge was served half a cycle earlier.
    localparam int      WRITE_VISIBLE = 6 * CLK_HALF;

    // Stream bits per test group; a bit takes at most 5 cycles.
    localparam int SETUP_BITS      = 3 * 136 + 2 * (8 * 4 + 12 * 16 + 32 * 4);
    localparam int THRESH_BITS     = 4 * 48 + 2 * 64;
    localparam int LOSS_BITS       = 40 + 4 * 32 + 8;
    localparam int TOTAL_BITS      = SETUP_BITS + THRESH_BITS + LOSS_BITS;
    localparam int HOST_ACCESSES   = 200;
    localparam int WATCHDOG_CYCLES = TOTAL_BITS * 5 + HOST_ACCESSES * 8 + RESET_CYCLES;

    logic           busClk;
    logic           rst;
    logic [3:0]     wr;
    logic           rd;
    busAddr         addr;
    busData         din;
    busData         dout;
    logic           rdAck;
    logic           dataBit;
    logic           bitStrobe;
    logic           framesync;

    logic [31:0]    lfsr;
    logic           frameBits [512];
    busData         prevWords [256];
    logic           wordSent [256];
    time            wordSentAt [256];
    logic           streamDone;

    framerTop u_framerTop (
        .busClk   (busClk),
        .rst      (rst),
        .wr       (wr),
        .rd       (rd),
        .addr     (addr),
        .din      (din),
        .dout     (dout),
        .rdAck    (rdAck),
        .dataBit  (dataBit),
        .bitStrobe(bitStrobe),
        .framesync(framesync)
    );

    initial begin
        busClk = 1'b0;
        forever #CLK_HALF busClk = ~busClk;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge busClk);
        failRun("Timeout: the test sequence did not finish in its time budget.");
    end

    initial begin
        wait (u_framerTop.u_framerTopAsserts.failCount != 0);
        failRun("A bound assertion on the bus or the buffer port failed.");
    end

    // ======================================================================
    // Reference model
    // ======================================================================

    function automatic logic [31:0] lfsrStep(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic int wordBitsOf(input wordLen bw);
        return (bw == '0) ? 32 : int'(bw);
    endfunction

    function automatic busData mergeLanes(input busData old, input busData nw,
                                          input logic [3:0] lanes);
        busData r;
        r = old;
        for (int lane = 0; lane < 4; lane++) begin
            if (lanes[lane]) begin
                r[lane*8 +: 8] = nw[lane*8 +: 8];
            end
        end
        return r;
    endfunction

    // Bits of a word arrive oldest first and end up at the top of the word.
    function automatic busData refWord(input int idx, input int wb);
        busData w;
        w = '0;
        for (int i = 0; i < wb; i++) begin
            w = {w[30:0], frameBits[idx * wb + i]};
        end
        return w;
    endfunction

    function automatic logic wordLanded(input int idx);
        return wordSent[idx] && ($time - wordSentAt[idx] > WRITE_VISIBLE);
    endfunction

    function automatic logic syncAccepted(input busData rx, input busData mask,
                                          input threshold thr);
        busData diff;
        int     errors;
        diff   = (rx ^ SYNC_WORD) & mask;
        errors = 0;
        for (int i = 0; i < 32; i++) begin
            errors += int'(diff[i]);
        end
        if (thr < 0) begin
            return 1'b0;
        end
        return errors <= int'(thr);
    endfunction

    function automatic busAddr bufAddr(input int idx);
        return `FRAME_BUF_BASE + busAddr'(idx * 4);
    endfunction

    // ======================================================================
    // Checks and bus access
    // ======================================================================

    task automatic failRun(input string reason);
        $display("%s", reason);
        $display("** FAIL **");
        $fatal(1);
    endtask

    task automatic checkValue(input string name, input busData got, input busData exp);
        if (got !== exp) begin
            failRun($sformatf("[ERROR] %0t ns: %s got 0x%08h, expected 0x%08h",
                              $time, name, got, exp));
        end
    endtask

    task automatic drawBits(input int n, output busData v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsrStep(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
    endtask

    task automatic writeReg(input busAddr a, input busData d, input logic [3:0] lanes);
        @(negedge busClk);
        addr = a;
        din  = d;
        wr   = lanes;
        @(negedge busClk);
        wr   = 4'b0000;
    endtask

    task automatic busRead(input busAddr a, output busData data);
        int waitCycles;
        @(negedge busClk);
        addr = a;
        rd   = 1'b1;
        @(negedge busClk);
        rd   = 1'b0;
        waitCycles = 0;
        while (!rdAck) begin
            @(negedge busClk);
            waitCycles++;
            if (waitCycles > 16) begin
                failRun($sformatf("No rdAck came for the read of address 0x%03h.", a));
            end
        end
        data = dout;
        // Register and unmapped reads answer one cycle after rd.
        if ((a & `FRAME_BUF_MASK) != `FRAME_BUF_BASE) begin
            checkValue("read latency", busData'(waitCycles), '0);
        end
    endtask

    task automatic expectStatus(input logic exp);
        busData v;
        busRead(`FRAMER_STATUS, v);
        checkValue("status", v, {31'b0, exp});
        checkValue("framesync", {31'b0, framesync}, {31'b0, exp});
    endtask

    task automatic setControl(input wordLen bw, input threshold thr, input frameLen wpf);
        writeReg(`FRAMER_CONTROL, {wpf, 1'b0, thr, 3'b000, bw}, 4'hF);
    endtask

    task automatic setSync(input busData mask);
        writeReg(`FRAMER_SYNCWORD, SYNC_WORD, 4'hF);
        writeReg(`FRAMER_SYNCWORD_MASK, mask, 4'hF);
    endtask

    // ======================================================================
    // Serial stream
    // ======================================================================

    // Called on a falling edge; strobes are 1 to 4 cycles apart.
    task automatic sendBit(input logic b);
        busData gap;
        drawBits(2, gap);
        dataBit   = b;
        bitStrobe = 1'b1;
        @(negedge busClk);
        bitStrobe = 1'b0;
        repeat (gap[1:0]) @(negedge busClk);
    endtask

    task automatic sendWord(input busData value, input int n);
        for (int i = n - 1; i >= 0; i--) begin
            sendBit(value[i]);
        end
    endtask

    task automatic sendRandom(input int n);
        busData b;
        for (int i = 0; i < n; i++) begin
            drawBits(1, b);
            sendBit(b[0]);
        end
    endtask

    task automatic genFrame(input int n);
        busData b;
        for (int i = 0; i < n; i++) begin
            drawBits(1, b);
            frameBits[i] = b[0];
        end
    endtask

    task automatic sendFrame(input int n, input int wb);
        for (int i = 0; i < 256; i++) begin
            wordSent[i] = 1'b0;
        end
        for (int i = 0; i < n; i++) begin
            if ((i + 1) % wb == 0) begin
                wordSentAt[i / wb] = $time;
                wordSent[i / wb]   = 1'b1;
            end
            sendBit(frameBits[i]);
        end
    endtask

    task automatic readFrame(input int words, input int wb);
        busData v;
        for (int i = 0; i < words; i++) begin
            busRead(bufAddr(i), v);
            checkValue($sformatf("buf[%0d]", i), v, refWord(i, wb));
        end
    endtask

    task automatic readDuringWrites(input int words, input int wb);
        busData got;
        busData exp;
        int     idx;
        idx = 0;
        while (!streamDone) begin
            repeat (3) @(negedge busClk);
            busRead(bufAddr(idx), got);
            // A word not yet rewritten still holds the previous frame.
            exp = wordLanded(idx) ? refWord(idx, wb) : prevWords[idx];
            checkValue($sformatf("buf[%0d]", idx), got, exp);
            idx = (idx + 1) % words;
        end
    endtask

    // ======================================================================
    // Test groups
    // ======================================================================

    task automatic testRegisters();
        busData v;
        busData sync;
        busAddr unmapped [4] = '{13'h010, 13'h100, 13'h800, 13'h1FFC};
        busRead(`FRAMER_CONTROL, v);
        checkValue("control", v, '0);
        writeReg(`FRAMER_SYNCWORD, 32'h1122_3344, 4'hF);
        writeReg(`FRAMER_SYNCWORD, 32'hAABB_CCDD, 4'b0101);
        sync = mergeLanes(32'h1122_3344, 32'hAABB_CCDD, 4'b0101);
        busRead(`FRAMER_SYNCWORD, v);
        checkValue("syncword", v, sync);
        writeReg(`FRAMER_SYNCWORD_MASK, 32'h5566_7788, 4'hF);
        writeReg(`FRAMER_SYNCWORD_MASK, 32'h0000_0000, 4'b1010);
        busRead(`FRAMER_SYNCWORD_MASK, v);
        checkValue("syncwordMask", v, mergeLanes(32'h5566_7788, '0, 4'b1010));
        writeReg(13'h104, 32'hFFFF_FFFF, 4'hF);
        busRead(`FRAMER_SYNCWORD, v);
        checkValue("syncword", v, sync);
        writeReg(`FRAMER_CONTROL, 32'hFFFF_FFFF, 4'hF);
        busRead(`FRAMER_CONTROL, v);
        checkValue("control", v, CTRL_USED);
        writeReg(`FRAMER_CONTROL, 32'h0000_0000, 4'b0110);
        busRead(`FRAMER_CONTROL, v);
        checkValue("control", v, mergeLanes(32'hFFFF_FFFF, '0, 4'b0110) & CTRL_USED);
        foreach (unmapped[i]) begin
            busRead(unmapped[i], v);
            checkValue($sformatf("read of 0x%03h", unmapped[i]), v, '0);
        end
    endtask

    task automatic runSetup(input wordLen bw, input frameLen wpf);
        int wb;
        int nBits;
        wb    = wordBitsOf(bw);
        nBits = wb * int'(wpf);
        setControl(bw, threshold'(2), wpf);
        sendRandom(40);
        expectStatus(1'b0);
        sendWord(SYNC_WORD, 32);
        expectStatus(1'b1);
        genFrame(nBits);
        sendFrame(nBits, wb);
        sendWord(SYNC_WORD, 32);
        expectStatus(1'b1);
        readFrame(wpf, wb);
        for (int i = 0; i < int'(wpf); i++) begin
            prevWords[i] = refWord(i, wb);
        end
        genFrame(nBits);
        streamDone = 1'b0;
        fork
            begin
                sendFrame(nBits, wb);
                streamDone = 1'b1;
            end
            readDuringWrites(wpf, wb);
        join
        // Random bits in the verify window drop the lock.
        sendRandom(32);
        expectStatus(1'b0);
        readFrame(wpf, wb);
    endtask

    task automatic thresholdCase(input busData flips, input threshold thr);
        logic accepted;
        accepted = syncAccepted(SYNC_WORD ^ flips, THRESH_MASK, thr);
        setControl(5'd8, thr, 16'd4);
        sendRandom(16);
        sendWord(SYNC_WORD ^ flips, 32);
        expectStatus(accepted);
        if (accepted) begin
            sendRandom(64);
            expectStatus(1'b0);
        end
    endtask

    task automatic testLossOfLock();
        setControl(5'd8, threshold'(2), 16'd4);
        sendRandom(40);
        sendWord(SYNC_WORD, 32);
        expectStatus(1'b1);
        genFrame(32);
        sendFrame(32, 8);
        // Three flipped bits, one more than the threshold.
        sendWord(SYNC_WORD ^ 32'h0000_0E00, 32);
        expectStatus(1'b0);
        sendRandom(8);
        sendWord(SYNC_WORD, 32);
        expectStatus(1'b1);
    endtask

    initial begin
        lfsr       = 32'hf374_21be;
        rst        = 1'b1;
        wr         = 4'b0000;
        rd         = 1'b0;
        addr       = '0;
        din        = '0;
        dataBit    = 1'b0;
        bitStrobe  = 1'b0;
        streamDone = 1'b0;
        repeat (RESET_CYCLES) @(negedge busClk);
        rst = 1'b0;

        expectStatus(1'b0);
        testRegisters();
        setSync(32'hFFFF_FFFF);
        runSetup(5'd8, 16'd4);
        runSetup(5'd12, 16'd16);
        runSetup(5'd0, 16'd4);
        setSync(THRESH_MASK);
        thresholdCase(32'h8010_0001, threshold'(3));
        thresholdCase(32'h8010_0021, threshold'(3));
        thresholdCase(32'h0000_F000, threshold'(0));
        thresholdCase(32'h0000_0000, threshold'(-1));
        setSync(32'hFFFF_FFFF);
        testLossOfLock();

        $display("** PASS **");
        $finish;
    end

endmodule

// ==== framerTb_asserts.sv ====
`timescale 1ns/1ns

module framerTopAsserts (
    input  logic        busClk,
    input  logic        rst,
    input  logic        rd,
    input  logic        rdAck,
    input  logic        framesync,
    input  logic        bufWriteEn,
    input  logic        bufRdAck
);

    logic   outstanding;
    int     failCount = 0;

    // A read is outstanding from its rd pulse until its acknowledge.
    always_ff @(posedge busClk) begin
        if (rst) begin
            outstanding <= 1'b0;
        end else if (rd) begin
            outstanding <= 1'b1;
        end else if (rdAck) begin
            outstanding <= 1'b0;
        end
    end

    ackNeedsRead: assert property (@(posedge busClk) disable iff (rst)
        rdAck |-> outstanding)
        else begin
            failCount++;
            $error("rdAck seen with no outstanding read");
        end

    quietAfterReset: assert property (@(posedge busClk)
        rst |=> (!rdAck && !framesync))
        else begin
            failCount++;
            $error("rdAck or framesync high right after reset");
        end

    // A write cycle on the shared port cannot also serve a read.
    portExclusive: assert property (@(posedge busClk) disable iff (rst)
        bufWriteEn |=> !bufRdAck)
        else begin
            failCount++;
            $error("buffer write and host read served in the same cycle");
        end

endmodule

bind framerTop framerTopAsserts u_framerTopAsserts (
    .busClk      (busClk),
    .rst         (rst),
    .rd          (rd),
    .rdAck       (rdAck),
    .framesync   (framesync),
    .bufWriteEn  (wrReq.en),
    .bufRdAck    (bufAck)
);

// ==== framerTop.sv ====
`timescale 1ns/1ns
`include "addressMap_defs.svh"

module framerTop
    import framerPkg::*;
(
    input  logic        busClk,
    input  logic        rst,
    input  logic [3:0]  wr,
    input  logic        rd,
    input  busAddr      addr,
    input  busData      din,
    output busData      dout,
    output logic        rdAck,
    input  logic        dataBit,
    input  logic        bitStrobe,
    output logic        framesync
);

    logic           regSel;
    logic           bufSel;
    logic           unmappedAck;
    logic           regsAck;
    logic           bufAck;
    busData         regsData;
    busData         bufData;
    framerCfg       cfg;
    corrStatus      corr;
    bufWrite        wrReq;
    logic           locked;

    // ======================================================================
    // Region decode and read return
    // ======================================================================

    assign regSel = (addr & `FRAMER_REGION_MASK) == `FRAMER_SPACE;
    assign bufSel = (addr & `FRAME_BUF_MASK) == `FRAME_BUF_BASE;

    // Reads outside both regions still complete, with zero data.
    always_ff @(posedge busClk) begin
        if (rst) begin
            unmappedAck <= 1'b0;
        end else begin
            unmappedAck <= rd && !regSel && !bufSel;
        end
    end

    assign dout      = regsData | bufData;
    assign rdAck     = regsAck | bufAck | unmappedAck;
    assign framesync = locked;

    framerRegs u_framerRegs (
        .busClk (busClk),   .rst   (rst),      .wr     (wr),
        .rd     (rd),       .addr  (addr),     .din    (din),
        .regSel (regSel),   .locked(locked),   .rdData (regsData),
        .rdAck  (regsAck),  .cfg   (cfg)
    );

    syncCorrelator u_syncCorrelator (
        .busClk (busClk),   .rst   (rst),      .dataBit(dataBit),
        .bitStrobe(bitStrobe), .cfg(cfg),      .corr   (corr)
    );

    frameSync u_frameSync (
        .busClk (busClk),   .rst   (rst),      .cfg    (cfg),
        .corr   (corr),     .wrReq (wrReq),    .locked (locked)
    );

    frameBuffer u_frameBuffer (
        .busClk (busClk),   .rst   (rst),      .wrReq  (wrReq),
        .rd     (rd && bufSel),
        .rdIndex(bufIndex'(addr >> 2)),
        .rdData (bufData),  .rdAck (bufAck)
    );

endmodule

// ==== frameBuffer.sv ====
`timescale 1ns/1ns
`include "addressMap_defs.svh"

module frameBuffer
    import framerPkg::*;
(
    input  logic        busClk,
    input  logic        rst,
    input  bufWrite     wrReq,
    input  logic        rd,
    input  bufIndex     rdIndex,
    output busData      rdData,
    output logic        rdAck
);

    busData         mem [`FRAME_BUF_DEPTH];
    logic           pending;
    bufIndex        pendIndex;
    bufIndex        readIndex;
    logic           readServe;

    // ======================================================================
    // Fixed priority arbiter
    // ======================================================================

    // Synchronizer writes own the port; a host read waits for a free cycle.
    assign readServe = (rd || pending) && !wrReq.en;
    assign readIndex = pending ? pendIndex : rdIndex;

    always_ff @(posedge busClk) begin
        if (rst) begin
            pending <= 1'b0;
            rdAck   <= 1'b0;
        end else begin
            rdAck <= readServe;
            if (readServe) begin
                pending <= 1'b0;
            end else if (rd) begin
                pending <= 1'b1;
            end
        end
    end

    always_ff @(posedge busClk) begin
        if (rd) begin
            pendIndex <= rdIndex;
        end
    end

    // Shared memory port.
    always_ff @(posedge busClk) begin
        if (wrReq.en) begin
            mem[wrReq.index] <= wrReq.data;
        end
        rdData <= readServe ? mem[readIndex] : '0;
    end

endmodule

// ==== frameSync.sv ====
`timescale 1ns/1ns

module frameSync
    import framerPkg::*;
(
    input  logic        busClk,
    input  logic        rst,
    input  framerCfg    cfg,
    input  corrStatus   corr,
    output bufWrite     wrReq,
    output logic        locked
);

    syncState       state;
    logic [5:0]     bitCount;
    logic [5:0]     verifyCount;
    logic [5:0]     wordBits;
    frameLen        wordCount;
    busData         wordMask;
    logic           wordDone;
    logic           frameDone;
    logic           wrEn;
    bufIndex        wrIndex;
    busData         wrData;

    // A word length of zero means a full 32-bit word.
    assign wordBits  = (cfg.bitsPerWord == '0) ? 6'd32 : {1'b0, cfg.bitsPerWord};
    assign wordMask  = ~({$bits(busData){1'b1}} << wordBits);
    assign wordDone  = corr.bitTick && (bitCount + 6'd1 == wordBits);
    assign frameDone = ({1'b0, wordCount} + 17'd1) >= {1'b0, cfg.wordsPerFrame};

    assign locked = (state != searching);
    assign wrReq  = '{en: wrEn, index: wrIndex, data: wrData};

    // ======================================================================
    // Search, lock and verify
    // ======================================================================

    always_ff @(posedge busClk) begin
        if (rst) begin
            state       <= searching;
            bitCount    <= '0;
            verifyCount <= '0;
            wordCount   <= '0;
            wrEn        <= 1'b0;
        end else begin
            wrEn <= 1'b0;
            case (state)
                searching: begin
                    if (corr.hit) begin
                        state     <= framerPkg::locked;
                        bitCount  <= '0;
                        wordCount <= '0;
                    end
                end
                framerPkg::locked: begin
                    if (wordDone) begin
                        bitCount  <= '0;
                        wordCount <= wordCount + 1'b1;
                        wrEn      <= 1'b1;
                        if (frameDone) begin
                            state       <= verifying;
                            verifyCount <= '0;
                        end
                    end else if (corr.bitTick) begin
                        bitCount <= bitCount + 1'b1;
                    end
                end
                verifying: begin
                    // The next sync word must end exactly 32 bits later.
                    if (corr.bitTick) begin
                        if (verifyCount == 6'd31) begin
                            if (corr.hit) begin
                                state     <= framerPkg::locked;
                                bitCount  <= '0;
                                wordCount <= '0;
                            end else begin
                                state <= searching;
                            end
                        end else begin
                            verifyCount <= verifyCount + 1'b1;
                        end
                    end
                end
                default: state <= searching;
            endcase
        end
    end

    always_ff @(posedge busClk) begin
        if (wordDone && state == framerPkg::locked) begin
            wrIndex <= bufIndex'(wordCount);
            wrData  <= corr.shiftReg & wordMask;
        end
    end

endmodule

// ==== syncCorrelator.sv ====
`timescale 1ns/1ns

module syncCorrelator
    import framerPkg::*;
(
    input  logic        busClk,
    input  logic        rst,
    input  logic        dataBit,
    input  logic        bitStrobe,
    input  framerCfg    cfg,
    output corrStatus   corr
);

    busData         shifted;
    busData         diff;
    logic [5:0]     mismatches;
    logic           match;

    // The newest bit enters at bit 0.
    assign shifted = {corr.shiftReg[$bits(busData)-2:0], dataBit};

    // Only bits inside the mask can count as errors.
    assign diff = (shifted ^ cfg.syncword) & cfg.syncwordMask;

    always_comb begin
        mismatches = '0;
        for (int i = 0; i < $bits(busData); i++) begin
            mismatches = mismatches + 6'(diff[i]);
        end
    end

    // A negative threshold disables detection.
    assign match = !cfg.syncThreshold[$bits(threshold)-1] &&
                   (mismatches <= cfg.syncThreshold[5:0]);

    // ======================================================================
    // Output register
    // ======================================================================

    always_ff @(posedge busClk) begin
        if (rst) begin
            corr <= '0;
        end else begin
            corr.bitTick <= bitStrobe;
            if (bitStrobe) begin
                corr.shiftReg <= shifted;
                corr.hit      <= match;
            end else begin
                corr.hit <= 1'b0;
            end
        end
    end

endmodule

// ==== framerRegs.sv ====
`timescale 1ns/1ns
`include "addressMap_defs.svh"

module framerRegs
    import framerPkg::*;
(
    input  logic        busClk,
    input  logic        rst,
    input  logic [3:0]  wr,
    input  logic        rd,
    input  busAddr      addr,
    input  busData      din,
    input  logic        regSel,
    input  logic        locked,
    output busData      rdData,
    output logic        rdAck,
    output framerCfg    cfg
);

    logic   regRead;

    assign regRead = rd && regSel;

    // ======================================================================
    // Byte-lane writes
    // ======================================================================

    always_ff @(posedge busClk) begin
        if (rst) begin
            cfg <= '0;
        end else if (regSel) begin
            // The control register packs its fields into separate lanes.
            if (wr[0] && addr == `FRAMER_CONTROL) begin
                cfg.bitsPerWord <= din[4:0];
            end
            if (wr[1] && addr == `FRAMER_CONTROL) begin
                cfg.syncThreshold <= din[14:8];
            end
            if (wr[2] && addr == `FRAMER_CONTROL) begin
                cfg.wordsPerFrame[7:0] <= din[23:16];
            end
            if (wr[3] && addr == `FRAMER_CONTROL) begin
                cfg.wordsPerFrame[15:8] <= din[31:24];
            end
            for (int lane = 0; lane < 4; lane++) begin
                if (wr[lane]) begin
                    case (addr)
                        `FRAMER_SYNCWORD: begin
                            cfg.syncword[lane*8 +: 8] <= din[lane*8 +: 8];
                        end
                        `FRAMER_SYNCWORD_MASK: begin
                            cfg.syncwordMask[lane*8 +: 8] <= din[lane*8 +: 8];
                        end
                        default: ;
                    endcase
                end
            end
        end
    end

    // ======================================================================
    // Registered reads
    // ======================================================================

    always_ff @(posedge busClk) begin
        if (rst) begin
            rdAck <= 1'b0;
        end else begin
            rdAck <= regRead;
        end
    end

    // Idle cycles drive zero so the top can OR the read buses.
    always_ff @(posedge busClk) begin
        rdData <= '0;
        if (regRead) begin
            case (addr)
                `FRAMER_CONTROL: begin
                    rdData <= {cfg.wordsPerFrame, 1'b0, cfg.syncThreshold,
                               3'b0, cfg.bitsPerWord};
                end
                `FRAMER_SYNCWORD:       rdData <= cfg.syncword;
                `FRAMER_SYNCWORD_MASK:  rdData <= cfg.syncwordMask;
                `FRAMER_STATUS:         rdData <= {31'b0, locked};
                default:                rdData <= '0;
            endcase
        end
    end

endmodule

// ==== framerPkg.sv ====
`include "addressMap_defs.svh"

package framerPkg;

    typedef logic [`BUS_ADDR_WIDTH-1:0]         busAddr;
    typedef logic [`BUS_DATA_WIDTH-1:0]         busData;
    typedef logic [`BUF_INDEX_WIDTH-1:0]        bufIndex;
    typedef logic [`WORD_LEN_WIDTH-1:0]         wordLen;
    typedef logic [`FRAME_LEN_WIDTH-1:0]        frameLen;
    typedef logic signed [`THRESH_WIDTH-1:0]    threshold;

    // Host programmed framing setup.
    typedef struct packed {
        wordLen     bitsPerWord;
        frameLen    wordsPerFrame;
        busData     syncwordMask;
        busData     syncword;
        threshold   syncThreshold;
    } framerCfg;

    // Correlator output, all fields registered together.
    typedef struct packed {
        logic       bitTick;
        logic       hit;
        busData     shiftReg;
    } corrStatus;

    typedef struct packed {
        logic       en;
        bufIndex    index;
        busData     data;
    } bufWrite;

    typedef enum logic [1:0] {
        searching,
        locked,
        verifying
    } syncState;

endpackage

// ==== addressMap_defs.svh ====
`ifndef ADDRESSMAP_DEFS_SVH
`define ADDRESSMAP_DEFS_SVH

// ==========================================================================
// Bus and data widths
// ==========================================================================

`define BUS_ADDR_WIDTH          13
`define BUS_DATA_WIDTH          32
`define BUF_INDEX_WIDTH         8
`define WORD_LEN_WIDTH          5
`define FRAME_LEN_WIDTH         16
`define THRESH_WIDTH            7

// ==========================================================================
// Register region, 0x000 to 0x0FF
// ==========================================================================

`define FRAMER_SPACE            13'h000
`define FRAMER_REGION_MASK      13'h1F00
`define FRAMER_CONTROL          13'h000
`define FRAMER_SYNCWORD         13'h004
`define FRAMER_SYNCWORD_MASK    13'h008
`define FRAMER_STATUS           13'h00C

// ==========================================================================
// Frame buffer window, read only
// ==========================================================================

// One word per 4 bytes, so 256 words fill 0x400 to 0x7FF.
`define FRAME_BUF_BASE          13'h400
`define FRAME_BUF_MASK          13'h1C00
`define FRAME_BUF_DEPTH         256

`endif
